/* sim/fetch_testdata.hex */
// words 0..63 memory image, word 64 test count
// each test: target mode old_target count, then records pc inst flags (bit1 compressed, bit0 illegal)
00100093 00200113 002081b3 00001237 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
81b34515 85aa0020 00010505 00001237 0093962e 00010010 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
557d0505 72fd6285 962e85aa bffda021 40000001 00018082 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000007
// aligned 32-bit run
00000000 00000000 00000000 00000004
00000000 00100093 0 00000004 00200113 0 00000008 002081b3 0 0000000c 00001237 0
// mixed code with straddling words
00000040 00000000 00000000 00000009
00000040 00500513 2 00000042 002081b3 0 00000046 00a005b3 2
00000048 00150513 2 0000004a 00000013 2 0000004c 00001237 0
00000050 00b60633 2 00000052 00100093 0 00000056 00000013 2
// misaligned targets, stitched then upper half
00000042 00000000 00000000 00000003
00000042 002081b3 0 00000046 00a005b3 2 00000048 00150513 2
00000046 00000000 00000000 00000002
00000046 00a005b3 2 00000048 00150513 2
// expansion of each supported form and two unsupported ones
00000080 00000000 00000000 0000000c
00000080 00150513 2 00000082 fff00513 2 00000084 000012b7 2
00000086 fffff2b7 2 00000088 00a005b3 2 0000008a 00b60633 2
0000008c 0080006f 2 0000008e fffff06f 2 00000090 00000013 2
00000092 00004000 3 00000094 00008082 3 00000096 00000013 2
// mixed code with random run
00000040 00000001 00000000 00000009
00000040 00500513 2 00000042 002081b3 0 00000046 00a005b3 2
00000048 00150513 2 0000004a 00000013 2 0000004c 00001237 0
00000050 00b60633 2 00000052 00100093 0 00000056 00000013 2
// redirect while a read of the old stream is outstanding
00000080 00000002 00000000 00000003
00000080 00150513 2 00000082 fff00513 2 00000084 000012b7 2

/* verilog.f */
src/fetch_pkg.sv
src/imem_port.sv
src/fetch_buffer.sv
src/rvc_expander.sv
src/fetch_unit.sv
sim/fetch_unit_assertions.sv
sim/fetch_unit_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = fetch_unit_tb
FILELIST  = verilog.f
BUILD     = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* sim/fetch_unit_tb.sv */
module fetch_unit_tb;
    import fetch_pkg::*;

    localparam int MEM_WORDS     = 64;
    localparam int DATA_WORDS    = 512;
    localparam int VALID_TIMEOUT = 200;      // cycles allowed per record

    logic       clk;
    logic       n_rst;
    logic       load_en;
    addr_t      load_addr;
    word_t      load_data;
    logic       redirect;
    addr_t      redirect_pc;
    logic       run;
    fetch_out_t out;
    logic       out_valid;

    word_t data [DATA_WORDS];                // memory image followed by test records
    int    ptr;
    int    errors;
    int    checks;
    int    tests;
    logic  random_run;

    fetch_unit #(
        .RESET_PC (32'h200),
        .MEM_WORDS(MEM_WORDS)
    ) fetch_unit_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .run        (run),
        .out        (out),
        .out_valid  (out_valid)
    );

    always #2 clk = ~clk;

    // inputs change and outputs are sampled 1 unit after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic load_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            load_en   = 1'b1;
            load_addr = addr_t'(i);
            load_data = data[i];
            step();
        end
        load_en = 1'b0;
    endtask

    task automatic pulse_redirect(input addr_t target);
        redirect    = 1'b1;
        redirect_pc = target;
        step();
        redirect    = 1'b0;
    endtask

    // let any read in flight finish and drop its output
    task automatic drain();
        run        = 1'b0;
        random_run = 1'b0;
        repeat (4) step();
    endtask

    task automatic wait_valid(output logic ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < VALID_TIMEOUT) begin
            if (random_run) begin
                run = 1'($urandom);
            end
            step();
            ok = out_valid;
            cycles++;
        end
        if (!ok) begin
            $display("timed out waiting for out_valid");
            errors++;
        end
    endtask

    task automatic check_out(input fetch_out_t act, input fetch_out_t exp);
        checks++;
        if (act.pc !== exp.pc) begin
            $display("ERROR out.pc expected %h actual %h", exp.pc, act.pc);
            errors++;
        end
        if (act.inst !== exp.inst) begin
            $display("ERROR out.inst expected %h actual %h (pc %h)", exp.inst, act.inst, exp.pc);
            errors++;
        end
        if (act.compressed !== exp.compressed) begin
            $display("ERROR out.compressed expected %h actual %h (pc %h)",
                     exp.compressed, act.compressed, exp.pc);
            errors++;
        end
        if (act.illegal !== exp.illegal) begin
            $display("ERROR out.illegal expected %h actual %h (pc %h)",
                     exp.illegal, act.illegal, exp.pc);
            errors++;
        end
    endtask

    // each test opens with target, mode, old target and record count
    // mode 1 toggles run at random and mode 2 redirects twice
    task automatic run_test();
        addr_t      target;
        word_t      mode;
        addr_t      old_pc;
        int         count;
        int         start_errors;
        fetch_out_t exp;
        logic       ok;
        target       = data[ptr];
        mode         = data[ptr + 1];
        old_pc       = data[ptr + 2];
        count        = int'(data[ptr + 3]);
        ptr          = ptr + 4;
        start_errors = errors;
        ok           = 1'b1;
        drain();
        random_run = (mode == 32'd1);
        run        = 1'b1;
        if (mode == 32'd2) begin
            pulse_redirect(old_pc);
            step();                           // read of the old stream now in flight
            if (fetch_unit_inst.imem_port_inst.outstanding !== 1'b1) begin
                $display("no read was outstanding when the second redirect came");
                errors++;
            end
        end
        pulse_redirect(target);
        for (int i = 0; i < count; i++) begin
            exp.pc         = data[ptr];
            exp.inst       = data[ptr + 1];
            exp.compressed = data[ptr + 2][1];
            exp.illegal    = data[ptr + 2][0];
            ptr            = ptr + 3;
            if (ok) begin
                wait_valid(ok);
                if (ok) begin
                    check_out(out, exp);
                end
            end
        end
        $display("test %0d target %h: %0d records, %s", tests, target, count,
                 (errors == start_errors) ? "ok" : "mismatch");
    endtask

    initial begin
        int seed_value;
        clk         = 1'b0;
        n_rst       = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        run         = 1'b0;
        random_run  = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        seed_value  = $urandom(32'hd323_19d2);
        $readmemh("sim/fetch_testdata.hex", data);
        repeat (4) @(posedge clk);
        #1;
        n_rst = 1'b1;
        load_memory();
        ptr = MEM_WORDS + 1;
        for (int t = 0; t < int'(data[MEM_WORDS]); t++) begin
            tests++;
            run_test();
        end
        drain();
        errors = errors + fetch_unit_inst.fetch_unit_assertions_inst.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* sim/fetch_unit_assertions.sv */
module fetch_unit_assertions (
    input logic                  clk,
    input logic                  n_rst,
    input logic                  run,
    input logic                  load_en,
    input logic                  redirect,
    input fetch_pkg::fetch_req_t req,
    input fetch_pkg::fetch_rsp_t rsp,
    input logic                  done,
    input logic                  out_valid
);
    import fetch_pkg::*;

    int fail_count = 0;

    // a word only arrives after a read was issued the cycle before
    arrived_after_issue: assert property (@(posedge clk) disable iff (!n_rst)
        rsp.arrived |-> $past(run & req.valid & ~load_en & ~redirect))
        else begin
            $error("arrived without a read issued the cycle before");
            fail_count++;
        end

    req_aligned: assert property (@(posedge clk) disable iff (!n_rst)
        req.addr[1:0] == 2'b00)
        else begin
            $error("fetch address not word aligned");
            fail_count++;
        end

    valid_follows_done: assert property (@(posedge clk) disable iff (!n_rst)
        out_valid == $past(done))
        else begin
            $error("out_valid does not follow done by one cycle");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk) $rose(n_rst) |=> !out_valid)
        else begin
            $error("out_valid right after reset release");
            fail_count++;
        end

endmodule

bind fetch_unit fetch_unit_assertions fetch_unit_assertions_inst (
    .clk      (clk),
    .n_rst    (n_rst),
    .run      (run),
    .load_en  (load_en),
    .redirect (redirect),
    .req      (req),
    .rsp      (rsp),
    .done     (buf_out.done),
    .out_valid(out_valid)
);

/* src/fetch_unit.sv */
module fetch_unit #(
    parameter fetch_pkg::addr_t RESET_PC  = 32'h200,
    parameter int               MEM_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  load_en,
    input  fetch_pkg::addr_t      load_addr,     // word index
    input  fetch_pkg::word_t      load_data,
    input  logic                  redirect,      // one-cycle pulse
    input  fetch_pkg::addr_t      redirect_pc,
    input  logic                  run,
    output fetch_pkg::fetch_out_t out,
    output logic                  out_valid
);
    import fetch_pkg::*;

    fetch_req_t req;
    fetch_rsp_t rsp;
    buf_out_t   buf_out;

    imem_port #(
        .MEM_WORDS(MEM_WORDS)
    ) imem_port_inst (
        .clk      (clk),
        .n_rst    (n_rst),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .redirect (redirect),
        .run      (run),
        .req      (req),
        .rsp      (rsp)
    );

    // splits words into 16 and 32 bit instructions
    fetch_buffer #(
        .RESET_PC(RESET_PC)
    ) fetch_buffer_inst (
        .clk        (clk),
        .n_rst      (n_rst),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .rsp        (rsp),
        .req        (req),
        .out        (buf_out)
    );

    rvc_expander rvc_expander_inst (
        .clk      (clk),
        .n_rst    (n_rst),
        .in       (buf_out),
        .out      (out),
        .out_valid(out_valid)
    );

endmodule

/* src/rvc_expander.sv */
module rvc_expander (
    input  logic                  clk,
    input  logic                  n_rst,
    input  fetch_pkg::buf_out_t   in,
    output fetch_pkg::fetch_out_t out,
    output logic                  out_valid
);
    import fetch_pkg::*;

    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_JAL = 7'b1101111;

    half_t       c;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm6;           // sign-extended 6-bit immediate
    logic [19:0] lui_imm;
    logic [20:0] j_off;
    logic        is_c;
    word_t       exp_inst;
    logic        exp_illegal;

    assign c    = in.inst[15:0];
    assign rd   = c[11:7];
    assign rs2  = c[6:2];
    assign is_c = is_compressed(c);

    assign imm6    = {{6{c[12]}}, c[12], c[6:2]};
    assign lui_imm = {{14{c[12]}}, c[12], c[6:2]};

    // scattered c.j offset bits
    assign j_off = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11],
                    c[5:3], 1'b0};

    always_comb begin
        exp_inst    = in.inst;                     // full words and unsupported forms pass
        exp_illegal = 1'b1;
        case ({c[1:0], c[15:13]})
            5'b01_000: begin                       // c.addi and c.nop
                exp_inst    = {imm6, rd, 3'b000, rd, OP_IMM};
                exp_illegal = 1'b0;
            end
            5'b01_010: begin                       // c.li
                exp_inst    = {imm6, 5'd0, 3'b000, rd, OP_IMM};
                exp_illegal = 1'b0;
            end
            5'b01_011: begin
                // rd of 2 is c.addi16sp and a zero immediate is reserved
                if (rd != 5'd2 && lui_imm != '0) begin
                    exp_inst    = {lui_imm, rd, OP_LUI};
                    exp_illegal = 1'b0;
                end
            end
            5'b01_101: begin                       // c.j
                exp_inst    = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                               5'd0, OP_JAL};
                exp_illegal = 1'b0;
            end
            5'b10_100: begin
                if (rs2 != 5'd0) begin             // zero rs2 means jr, jalr, ebreak
                    if (c[12]) begin
                        exp_inst = {7'b0000000, rs2, rd, 3'b000, rd, OP_REG};    // c.add
                    end else begin
                        exp_inst = {7'b0000000, rs2, 5'd0, 3'b000, rd, OP_REG};  // c.mv
                    end
                    exp_illegal = 1'b0;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in.done;
        end
    end

    always_ff @(posedge clk) begin
        if (in.done) begin
            out.pc         <= in.pc;
            out.inst       <= exp_inst;
            out.compressed <= is_c;
            out.illegal    <= is_c & exp_illegal;
        end
    end

endmodule

/* src/fetch_buffer.sv */
module fetch_buffer #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h200
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  redirect,
    input  fetch_pkg::addr_t      redirect_pc,
    input  fetch_pkg::fetch_rsp_t rsp,
    output fetch_pkg::fetch_req_t req,
    output fetch_pkg::buf_out_t   out
);
    import fetch_pkg::*;

    addr_t pc;                 // pc of the next instruction to finish
    addr_t next_pc;
    addr_t count_read;         // aligned address of the next word to read
    addr_t next_count_read;
    half_t saved;              // upper parcel waiting for its second half
    half_t next_saved;
    logic  combine_q;
    logic  combine;
    logic  wait_next_q;
    logic  wait_next;
    logic  skip_q;             // misaligned target drops the first lower parcel
    logic  skip;
    word_t final_inst;
    logic  finished;
    half_t lo_half;
    half_t hi_half;

    // same arriving word viewed as two parcels
    assign lo_half = rsp.data.half.lo;
    assign hi_half = rsp.data.half.hi;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pc          <= RESET_PC;
            count_read  <= {RESET_PC[31:2], 2'b00};
            combine_q   <= 1'b0;
            wait_next_q <= 1'b0;
            skip_q      <= RESET_PC[1];
        end else if (redirect || rsp.arrived) begin
            pc          <= next_pc;
            count_read  <= next_count_read;
            combine_q   <= combine;
            wait_next_q <= wait_next;
            skip_q      <= skip;
        end
    end

    always_ff @(posedge clk) begin
        saved <= next_saved;
    end

    always_comb begin
        next_pc         = pc;
        next_count_read = count_read;
        next_saved      = saved;
        combine         = combine_q;
        wait_next       = wait_next_q;
        skip            = skip_q;
        final_inst      = '0;
        finished        = 1'b0;

        if (redirect) begin
            next_count_read = {redirect_pc[31:2], 2'b00};
            next_pc         = redirect_pc;                 // may be halfword aligned
            combine         = 1'b0;
            wait_next       = 1'b0;
            skip            = redirect_pc[1];
        end else if (rsp.arrived) begin
            combine   = 1'b0;
            wait_next = 1'b0;
            skip      = 1'b0;
            if (skip_q) begin
                next_count_read = count_read + 32'd4;
                if (is_compressed(hi_half)) begin
                    final_inst = {16'h0000, hi_half};
                    next_pc    = pc + 32'd2;
                    finished   = 1'b1;
                end else begin
                    next_saved = hi_half;                  // straddles into next word
                    combine    = 1'b1;
                end
            end else if (combine_q) begin
                final_inst = {lo_half, saved};             // stitched instruction
                next_pc    = pc + 32'd4;
                finished   = 1'b1;
                if (is_compressed(hi_half)) begin
                    wait_next = 1'b1;                      // read this word again
                end else begin
                    next_saved      = hi_half;
                    combine         = 1'b1;
                    next_count_read = count_read + 32'd4;
                end
            end else if (wait_next_q) begin
                final_inst      = {16'h0000, hi_half};
                next_pc         = pc + 32'd2;
                finished        = 1'b1;
                next_count_read = count_read + 32'd4;
            end else if (is_compressed(lo_half)) begin
                final_inst = {16'h0000, lo_half};
                next_pc    = pc + 32'd2;
                finished   = 1'b1;
                if (is_compressed(hi_half)) begin
                    wait_next = 1'b1;
                end else begin
                    next_saved      = hi_half;
                    combine         = 1'b1;
                    next_count_read = count_read + 32'd4;
                end
            end else begin
                final_inst      = rsp.data.word;           // aligned full word
                next_pc         = pc + 32'd4;
                finished        = 1'b1;
                next_count_read = count_read + 32'd4;
            end
        end
    end

    always_comb begin
        req.addr  = count_read;
        req.valid = ~redirect;          // address is stale while reloading
        out.pc    = pc;
        out.inst  = final_inst;
        out.done  = finished;
    end

endmodule

/* src/imem_port.sv */
module imem_port #(
    parameter int MEM_WORDS = 64
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  load_en,
    input  fetch_pkg::addr_t      load_addr,     // word index
    input  fetch_pkg::word_t      load_data,
    input  logic                  redirect,
    input  logic                  run,
    input  fetch_pkg::fetch_req_t req,
    output fetch_pkg::fetch_rsp_t rsp
);
    import fetch_pkg::*;

    word_t mem [MEM_WORDS];
    word_t rdata;
    logic  outstanding;
    logic  issue;
    addr_t rd_index;
    addr_t wr_index;

    // word address wraps onto the array depth
    assign rd_index = (req.addr >> 2) % addr_t'(MEM_WORDS);
    assign wr_index = load_addr % addr_t'(MEM_WORDS);

    // one read in flight at a time, loads and redirects take the cycle
    assign issue = run & req.valid & ~outstanding & ~load_en & ~redirect;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            outstanding <= 1'b0;
        end else begin
            outstanding <= issue;              // read returns next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[wr_index] <= load_data;
        end
        if (issue) begin
            rdata <= mem[rd_index];            // address sampled at issue
        end
    end

    // a redirect in the return cycle drops the word
    always_comb begin
        rsp.data.word = rdata;
        rsp.arrived   = outstanding & ~redirect;
    end

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

    typedef logic [31:0] addr_t;    // byte address
    typedef logic [31:0] word_t;    // one instruction memory word
    typedef logic [15:0] half_t;    // 16-bit parcel

    typedef struct packed {
        half_t hi;                  // bits 31:16 of the word
        half_t lo;                  // bits 15:0 of the word
    } half_pair_t;

    // an arriving word is read whole or as two parcels
    typedef union packed {
        word_t      word;
        half_pair_t half;
    } fetch_word_u;

    typedef struct packed {
        addr_t addr;                // always word aligned
        logic  valid;
    } fetch_req_t;

    typedef struct packed {
        fetch_word_u data;
        logic        arrived;       // one-cycle strobe
    } fetch_rsp_t;

    typedef struct packed {
        addr_t pc;
        word_t inst;                // compressed forms sit in bits 15:0
        logic  done;
    } buf_out_t;

    typedef struct packed {
        addr_t pc;
        word_t inst;
        logic  compressed;
        logic  illegal;
    } fetch_out_t;

    // any parcel whose low two bits are not 2'b11 is a 16-bit instruction
    function automatic logic is_compressed(half_t h);
        return h[1:0] != 2'b11;
    endfunction

endpackage
